// File: Makefile
VERILATOR ?= verilator
TOP       ?= dcache_tb
FLIST     ?= all.f
BUILD     ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "tests failed" $(LOG) || ! grep -q "all tests passed" $(LOG); then \
		exit 1; fi

clean:
	rm -rf $(BUILD) $(LOG)

// File: all.f
hw/dcache_pkg.sv
hw/axi_burst_master.sv
hw/dcache_way_ram.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
dv/axi_mem_model.sv
dv/dcache_assert.sv
dv/dcache_tb.sv

// File: dv/axi_mem_model.sv
`timescale 1ns/1ps

module axi_mem_model #(
    parameter int rd_delay = 3,
    parameter int wr_delay = 2
) (
    input  logic        clk,
    input  logic        rst,
    input  logic [31:0] araddr,
    input  logic [7:0]  arlen,
    input  logic        arvalid,
    input  logic        rready,
    output logic        arready,
    output logic [31:0] rdata,
    output logic        rvalid,
    output logic        rlast,
    input  logic [31:0] awaddr,
    input  logic [7:0]  awlen,
    input  logic        awvalid,
    input  logic [31:0] wdata,
    input  logic [3:0]  wstrb,
    input  logic        wlast,
    input  logic        wvalid,
    input  logic        bready,
    output logic        awready,
    output logic        wready,
    output logic        bvalid
);
    logic [31:0] mem [logic [29:0]];
    logic        rd_busy;
    logic [31:0] rd_ptr, wr_ptr;
    logic [8:0]  rd_left;
    logic [1:0]  wr_phase;   // 0 addr, 1 data, 2 resp
    int          rd_wait, wr_wait;

    // untouched words hold a pattern of their full address
    function automatic logic [31:0] peek(input logic [31:0] addr);
        if (mem.exists(addr[31:2])) return mem[addr[31:2]];
        return (addr * 32'h9e3779b1) ^ 32'h5a5a0f0f;
    endfunction

    task automatic poke(input logic [31:0] addr, input logic [31:0] value);
        mem[addr[31:2]] = value;
    endtask

    // slave outputs quiet until the first falling edge
    initial begin
        arready <= 1'b0;
        rdata   <= '0;
        rvalid  <= 1'b0;
        rlast   <= 1'b0;
        awready <= 1'b0;
        wready  <= 1'b0;
        bvalid  <= 1'b0;
    end

    always @(posedge clk) begin
        logic [31:0] word;
        if (rst) begin
            rd_busy  <= 1'b0;
            rd_ptr   <= '0;
            rd_left  <= '0;
            wr_phase <= 2'd0;
        end else begin
            if (!rd_busy && arvalid && arready) begin
                rd_busy <= 1'b1;
                rd_ptr  <= araddr;
                rd_left <= 9'(arlen) + 9'd1;
                rd_wait <= rd_delay;
            end else if (rd_busy && rvalid && rready) begin
                rd_ptr  <= rd_ptr + 32'd4;
                rd_left <= rd_left - 9'd1;
                if (rd_left == 9'd1) rd_busy <= 1'b0;
            end else if (rd_busy && rd_wait != 0) begin
                rd_wait <= rd_wait - 1;
            end

            if (wr_phase == 2'd0 && awvalid && awready) begin
                wr_ptr   <= awaddr;
                wr_phase <= 2'd1;
            end else if (wr_phase == 2'd1 && wvalid && wready) begin
                word = peek(wr_ptr);
                for (int b = 0; b < 4; b++) begin
                    if (wstrb[b]) word[8*b +: 8] = wdata[8*b +: 8];
                end
                mem[wr_ptr[31:2]] = word;
                wr_ptr <= wr_ptr + 32'd4;
                if (wlast) begin
                    wr_phase <= 2'd2;
                    wr_wait  <= wr_delay;
                end
            end else if (wr_phase == 2'd2) begin
                if (bvalid && bready) wr_phase <= 2'd0;
                else if (wr_wait != 0) wr_wait <= wr_wait - 1;
            end
        end
    end

    // outputs move on the falling edge
    always @(negedge clk) begin
        arready <= !rst && !rd_busy;
        rvalid  <= rd_busy && rd_wait == 0;
        rdata   <= peek(rd_ptr);
        rlast   <= rd_left == 9'd1;
        awready <= !rst && wr_phase == 2'd0;
        wready  <= wr_phase == 2'd1;
        bvalid  <= wr_phase == 2'd2 && wr_wait == 0;
    end

endmodule

// File: dv/dcache_assert.sv
`timescale 1ns/1ps

module dcache_assert (
    input logic        clk,
    input logic        rst,
    input logic        cpu_req,
    input logic        cpu_uncached,
    input logic        cpu_ack,
    input logic        rd_start,
    input logic        wr_start,
    input logic [31:0] araddr,
    input logic        arvalid,
    input logic        arready,
    input logic        rready,
    input logic [31:0] awaddr,
    input logic [7:0]  awlen,
    input logic        awvalid,
    input logic        awready,
    input logic [31:0] wdata,
    input logic        wlast,
    input logic        wvalid,
    input logic        wready,
    input logic        bready
);
    logic       busy;
    logic       accept;
    logic [7:0] w_beats;
    int         failures = 0;

    assign accept = cpu_req && !busy && !cpu_ack;

    // mirrors the controller being away from idle
    always @(posedge clk) begin
        if (rst) begin
            busy    <= 1'b0;
            w_beats <= 8'd0;
        end else begin
            busy <= accept ? 1'b1 : (cpu_ack ? 1'b0 : busy);
            if (awvalid && awready) w_beats <= 8'd0;
            else if (wvalid && wready) w_beats <= w_beats + 8'd1;
        end
    end

    a_quiet_idle: assert property (@(posedge clk) disable iff (rst)
        !busy |-> !cpu_ack && !arvalid && !awvalid && !wvalid && !rready && !bready)
        else begin
            failures++;
            $error("control outputs active while cache idle");
        end

    a_hit_latency: assert property (@(posedge clk) disable iff (rst)
        accept && !cpu_uncached |-> ##2 (cpu_ack || rd_start || wr_start))
        else begin
            failures++;
            $error("cached access neither acked nor missed two cycles after request");
        end

    a_ar_hold: assert property (@(posedge clk) disable iff (rst)
        arvalid && !arready |=> arvalid && $stable(araddr))
        else begin
            failures++;
            $error("arvalid or araddr changed before arready");
        end

    a_aw_hold: assert property (@(posedge clk) disable iff (rst)
        awvalid && !awready |=> awvalid && $stable(awaddr))
        else begin
            failures++;
            $error("awvalid or awaddr changed before awready");
        end

    a_w_hold: assert property (@(posedge clk) disable iff (rst)
        wvalid && !wready |=> wvalid && $stable(wdata))
        else begin
            failures++;
            $error("wvalid or wdata changed before wready");
        end

    a_w_after_aw: assert property (@(posedge clk) disable iff (rst)
        wvalid |-> !awvalid)
        else begin
            failures++;
            $error("write data issued before address handshake");
        end

    a_wlast: assert property (@(posedge clk) disable iff (rst)
        wvalid |-> wlast == (w_beats == awlen))
        else begin
            failures++;
            $error("wlast not on the final write beat");
        end

endmodule

// File: dv/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    localparam int num_requests = 17;

    logic        clk, rst;
    logic        cpu_req, cpu_wr, cpu_uncached, cpu_ack;
    logic [31:0] cpu_addr, cpu_wdata, cpu_rdata;
    logic [3:0]  cpu_wstrb;
    logic [31:0] araddr, rdata, awaddr, wdata;
    logic [7:0]  arlen, awlen;
    logic        arvalid, rready, arready, rvalid, rlast;
    logic        awvalid, wlast, wvalid, bready, awready, wready, bvalid;
    logic [3:0]  wstrb;
    logic [31:0] shadow [logic [29:0]];
    int          seed = 5422;
    int          errors = 0;
    int          ar_count = 0;
    int          aw_count = 0;
    logic [7:0]  last_arlen;
    logic [7:0]  last_awlen;

    dcache_top UUT (.*);

    axi_mem_model mem (.*);

    bind dcache_top dcache_assert u_assert (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        if (arvalid && arready) begin
            ar_count   <= ar_count + 1;
            last_arlen <= arlen;
        end
        if (awvalid && awready) begin
            aw_count   <= aw_count + 1;
            last_awlen <= awlen;
        end
    end

    function automatic logic [31:0] expect_word(input logic [31:0] addr);
        if (shadow.exists(addr[31:2])) return shadow[addr[31:2]];
        return mem.peek(addr);
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
        return {21'(tag), 6'(set), 3'(word), 2'b00};
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic access(input logic wr, input logic unc, input logic [31:0] addr,
                          input logic [31:0] wd, input logic [3:0] strb,
                          output logic [31:0] rd, output int cycles);
        cpu_req      = 1'b1;
        cpu_wr       = wr;
        cpu_uncached = unc;
        cpu_addr     = addr;
        cpu_wdata    = wd;
        cpu_wstrb    = strb;
        cycles       = 0;
        do begin
            @(negedge clk);
            cycles++;
        end while (!cpu_ack);
        rd      = cpu_rdata;
        cpu_req = 1'b0;
        @(negedge clk);   // controller passes through respond
    endtask

    task automatic store(input logic [31:0] addr, input logic [31:0] wd, input logic [3:0] strb);
        logic [31:0] word;
        logic [31:0] rd;
        int          cycles;
        word = expect_word(addr);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) word[8*b +: 8] = wd[8*b +: 8];
        end
        shadow[addr[31:2]] = word;
        access(1'b1, 1'b0, addr, wd, strb, rd, cycles);
    endtask

    task automatic load_check(input logic [31:0] addr, input logic unc, output int cycles);
        logic [31:0] rd;
        access(1'b0, unc, addr, 32'h0, 4'h0, rd, cycles);
        check_val("cpu_rdata", rd, expect_word(addr));
    endtask

    initial begin
        int          cycles, ar_before, aw_before, tag;
        int          assert_errors;
        logic [31:0] a, b, c, d;
        rst = 1'b1;
        {cpu_req, cpu_wr, cpu_uncached} = '0;
        cpu_addr  = '0;
        cpu_wdata = '0;
        cpu_wstrb = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        repeat (3) @(negedge clk);

        // read miss, then a hit in the same line
        tag = $random(seed) & 32'hfff;
        a = make_addr(tag, 1, $random(seed) & 7);
        ar_before = ar_count;
        load_check(a, 1'b0, cycles);
        check_val("ar bursts", ar_count - ar_before, 1);
        check_val("arlen", last_arlen, 7);
        ar_before = ar_count;
        load_check(a ^ 32'h8, 1'b0, cycles);
        check_val("hit cycles", cycles, 2);
        check_val("ar bursts", ar_count - ar_before, 0);

        // store hit, store miss
        store(a, $random(seed), 4'b0101);
        load_check(a, 1'b0, cycles);
        b = make_addr(tag + 1, 7, 3);
        store(b, $random(seed), 4'b1110);
        load_check(b, 1'b0, cycles);

        // two dirty lines in one set, a third tag evicts one
        a = make_addr(tag + 2, 2, 1);
        b = make_addr(tag + 3, 2, 6);
        c = make_addr(tag + 4, 2, 0);
        store(a, $random(seed), 4'b1111);
        store(b, $random(seed), 4'b0011);
        aw_before = aw_count;
        load_check(c, 1'b0, cycles);
        check_val("aw bursts", aw_count - aw_before, 1);
        check_val("awlen", last_awlen, 7);
        load_check(a, 1'b0, cycles);

        // lru: A B A C keeps A
        a = make_addr(tag + 5, 3, 2);
        b = make_addr(tag + 6, 3, 2);
        c = make_addr(tag + 7, 3, 2);
        load_check(a, 1'b0, cycles);
        load_check(b, 1'b0, cycles);
        load_check(a, 1'b0, cycles);
        load_check(c, 1'b0, cycles);
        ar_before = ar_count;
        load_check(a, 1'b0, cycles);
        check_val("hit cycles", cycles, 2);
        check_val("ar bursts", ar_count - ar_before, 0);

        // uncached reads see backdoor changes
        d = make_addr(tag + 9, 9, 5);
        load_check(d, 1'b1, cycles);
        check_val("arlen", last_arlen, 0);
        shadow[d[31:2]] = $random(seed);
        mem.poke(d, shadow[d[31:2]]);
        load_check(d, 1'b1, cycles);

        assert_errors = UUT.u_assert.failures;
        $display("%0d check errors, %0d assertion errors", errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    initial begin
        #(num_requests * 200 * 10);
        $display("watchdog expired, a request never completed");
        $display("tests failed");
        $finish;
    end

endmodule

// File: hw/axi_burst_master.sv
`timescale 1ns/1ps

module axi_burst_master import dcache_pkg::*; #(
    parameter int line_bits = 5
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 rd_start,
    input  logic                 wr_start,
    input  logic [word_bits-1:0] line_addr,
    input  logic [line_bits-2:0] beat_count,
    input  logic [word_bits-1:0] wb_word,
    output logic                 wb_next,
    output logic [word_bits-1:0] beat_data,
    output logic                 beat_valid,
    output logic [line_bits-3:0] beat_idx,
    output logic                 done,
    output logic [word_bits-1:0] araddr,
    output logic [7:0]           arlen,
    output logic                 arvalid,
    output logic                 rready,
    input  logic                 arready,
    input  logic [word_bits-1:0] rdata,
    input  logic                 rvalid,
    input  logic                 rlast,
    output logic [word_bits-1:0] awaddr,
    output logic [7:0]           awlen,
    output logic                 awvalid,
    output logic [word_bits-1:0] wdata,
    output logic [strb_bits-1:0] wstrb,
    output logic                 wlast,
    output logic                 wvalid,
    output logic                 bready,
    input  logic                 awready,
    input  logic                 wready,
    input  logic                 bvalid
);
    logic [line_bits-3:0] beat_cnt;  // shared, one burst at a time
    logic [7:0]           burst_len;
    logic                 ar_fire, r_fire, aw_fire, w_fire, b_fire;

    assign burst_len = 8'(beat_count) - 8'd1;
    assign ar_fire   = arvalid & arready;
    assign r_fire    = rvalid & rready;
    assign aw_fire   = awvalid & awready;
    assign w_fire    = wvalid & wready;
    assign b_fire    = bvalid & bready;

    assign beat_data  = rdata;
    assign beat_valid = r_fire;
    assign beat_idx   = beat_cnt;
    assign done       = (r_fire & rlast) | b_fire;
    assign wb_next    = aw_fire | (w_fire & ~wlast);  // word loaded into wdata
    assign wstrb      = {strb_bits{1'b1}};

    always_ff @(posedge clk) begin
        if (rst) begin
            arvalid  <= 1'b0;
            rready   <= 1'b0;
            awvalid  <= 1'b0;
            wvalid   <= 1'b0;
            wlast    <= 1'b0;
            bready   <= 1'b0;
            beat_cnt <= '0;
        end else begin
            if (rd_start) arvalid <= 1'b1;
            if (ar_fire) begin
                arvalid  <= 1'b0;
                rready   <= 1'b1;
                beat_cnt <= '0;
            end
            if (r_fire) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (rlast) rready <= 1'b0;
            end

            if (wr_start) awvalid <= 1'b1;
            if (aw_fire) begin
                awvalid  <= 1'b0;
                wvalid   <= 1'b1;
                wlast    <= awlen == 8'd0;
                beat_cnt <= '0;
            end
            if (w_fire) begin
                if (wlast) begin
                    wvalid <= 1'b0;
                    wlast  <= 1'b0;
                    bready <= 1'b1;
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                    wlast    <= 8'(beat_cnt) + 8'd1 == awlen;
                end
            end
            if (b_fire) bready <= 1'b0;
        end
    end

    // address and data payload
    always_ff @(posedge clk) begin
        if (rd_start) begin
            araddr <= line_addr;
            arlen  <= burst_len;
        end
        if (wr_start) begin
            awaddr <= line_addr;
            awlen  <= burst_len;
        end
        if (wb_next) wdata <= wb_word;
    end

endmodule

// File: hw/dcache_ctrl.sv
`timescale 1ns/1ps

module dcache_ctrl import dcache_pkg::*; #(
    parameter int line_bits  = 5,
    parameter int index_bits = 6
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  logic                                        cpu_req,
    input  logic                                        cpu_wr,
    input  logic                                        cpu_uncached,
    input  logic [word_bits-1:0]                        cpu_addr,
    input  logic [word_bits-1:0]                        cpu_wdata,
    input  logic [strb_bits-1:0]                        cpu_wstrb,
    output logic                                        cpu_ack,
    output logic [word_bits-1:0]                        cpu_rdata,
    output logic [index_bits-1:0]                       rd_set,
    output logic [line_bits-3:0]                        rd_word,
    output logic [1:0]                                  way_we,
    output logic [index_bits-1:0]                       wr_set,
    output logic [line_bits-3:0]                        wr_word,
    output logic [strb_bits-1:0]                        wr_strb,
    output logic [word_bits-index_bits-line_bits-1:0]   wr_tag,
    output logic [word_bits-1:0]                        wr_data,
    input  logic [word_bits-index_bits-line_bits-1:0]   tag0,
    input  logic [word_bits-index_bits-line_bits-1:0]   tag1,
    input  logic [word_bits-1:0]                        data0,
    input  logic [word_bits-1:0]                        data1,
    output logic                                        rd_start,
    output logic                                        wr_start,
    output logic [word_bits-1:0]                        line_addr,
    output logic [line_bits-2:0]                        beat_count,
    output logic [word_bits-1:0]                        wb_word,
    input  logic                                        wb_next,
    input  logic [word_bits-1:0]                        beat_data,
    input  logic                                        beat_valid,
    input  logic [line_bits-3:0]                        beat_idx,
    input  logic                                        done
);
    localparam int word_idx_bits = line_bits - 2;
    localparam int tag_bits      = word_bits - index_bits - line_bits;
    localparam int sets          = 1 << index_bits;

    logic [ctrl_state_bits-1:0] state;
    logic [word_bits-1:0]       req_addr, req_wdata, merged;
    logic [strb_bits-1:0]       req_strb;
    logic                       req_wr;
    logic [1:0]                 valid [sets];
    logic [1:0]                 dirty [sets];
    logic [sets-1:0]            lru;   // way used last
    logic                       victim_way;
    logic [tag_bits-1:0]        victim_tag;
    logic [word_idx_bits-1:0]   wb_cnt;

    logic [word_idx_bits-1:0]   req_word;
    logic [index_bits-1:0]      req_set;
    logic [tag_bits-1:0]        req_tag;
    logic                       hit0, hit1, hit, miss_way, refilling, lookup;

    assign req_word  = req_addr[line_bits-1:2];
    assign req_set   = req_addr[line_bits+index_bits-1:line_bits];
    assign req_tag   = req_addr[word_bits-1:line_bits+index_bits];
    assign hit0      = valid[req_set][0] && tag0 == req_tag;
    assign hit1      = valid[req_set][1] && tag1 == req_tag;
    assign hit       = hit0 | hit1;
    assign miss_way  = ~lru[req_set];
    assign refilling = state == st_refill;
    assign lookup    = state == st_lookup;

    // idle reads straight from the cpu address so lookup has the tags
    assign rd_set  = (state == st_idle) ? cpu_addr[line_bits+index_bits-1:line_bits] : req_set;
    assign rd_word = (state == st_idle) ? cpu_addr[line_bits-1:2] :
                     (state == st_writeback) ? wb_cnt + word_idx_bits'(wb_next) : req_word;
    assign wb_word = victim_way ? data1 : data0;

    always_comb begin
        merged = beat_data;
        for (int b = 0; b < strb_bits; b++) begin
            if (req_strb[b]) merged[8*b +: 8] = req_wdata[8*b +: 8];
        end
    end

    assign wr_set  = req_set;
    assign wr_tag  = req_tag;
    assign wr_word = refilling ? beat_idx : req_word;
    assign wr_strb = refilling ? {strb_bits{1'b1}} : req_strb;
    assign wr_data = !refilling ? req_wdata :
                     (req_wr && beat_idx == req_word) ? merged : beat_data;
    assign way_we[0] = (lookup & req_wr & hit0) | (refilling & beat_valid & ~victim_way);
    assign way_we[1] = (lookup & req_wr & hit1) | (refilling & beat_valid & victim_way);

    assign line_addr = (state == st_writeback) ? {victim_tag, req_set, {line_bits{1'b0}}} :
                       (state == st_uncached) ? {req_addr[word_bits-1:2], 2'b00} :
                       {req_tag, req_set, {line_bits{1'b0}}};
    assign beat_count = (state == st_uncached) ? (line_bits-1)'(1) : (line_bits-1)'(1 << word_idx_bits);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= st_idle;
            cpu_ack  <= 1'b0;
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            valid    <= '{default: '0};
            dirty    <= '{default: '0};
            lru      <= '0;
            wb_cnt   <= '0;
        end else begin
            cpu_ack  <= 1'b0;
            rd_start <= 1'b0;
            wr_start <= 1'b0;
            case (state)
                st_idle: if (cpu_req) begin
                    state    <= cpu_uncached ? st_uncached : st_lookup;
                    rd_start <= cpu_uncached;
                end
                st_lookup: if (hit) begin
                    cpu_ack      <= 1'b1;
                    state        <= st_respond;
                    lru[req_set] <= hit1;
                    if (req_wr) dirty[req_set][hit1] <= 1'b1;
                end else if (valid[req_set][miss_way] && dirty[req_set][miss_way]) begin
                    state    <= st_writeback;
                    wr_start <= 1'b1;
                    wb_cnt   <= '0;
                end else begin
                    state    <= st_refill;
                    rd_start <= 1'b1;
                end
                st_writeback: begin
                    if (wb_next) wb_cnt <= wb_cnt + 1'b1;
                    if (done) begin      // line is out, fetch the new one
                        state    <= st_refill;
                        rd_start <= 1'b1;
                    end
                end
                st_refill: if (done) begin
                    valid[req_set][victim_way] <= 1'b1;
                    dirty[req_set][victim_way] <= req_wr;
                    lru[req_set]               <= victim_way;
                    cpu_ack                    <= 1'b1;
                    state                      <= st_respond;
                end
                st_uncached: if (done) begin
                    cpu_ack <= 1'b1;
                    state   <= st_respond;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && cpu_req) begin
            req_addr  <= cpu_addr;
            req_wr    <= cpu_wr & ~cpu_uncached;
            req_wdata <= cpu_wdata;
            req_strb  <= cpu_wstrb;
        end
        if (lookup) begin
            victim_way <= miss_way;
            victim_tag <= miss_way ? tag1 : tag0;
            cpu_rdata  <= hit1 ? data1 : data0;
        end
        // requested word as it arrives
        if (beat_valid && (state == st_uncached || beat_idx == req_word)) cpu_rdata <= beat_data;
    end

endmodule

// File: hw/dcache_pkg.sv
package dcache_pkg;

    localparam int word_bits = 32;
    localparam int strb_bits = 4;

    // ctrl_state encoding
    localparam int ctrl_state_bits = 3;

    localparam logic [ctrl_state_bits-1:0] st_idle      = 3'd0;
    localparam logic [ctrl_state_bits-1:0] st_lookup    = 3'd1;
    localparam logic [ctrl_state_bits-1:0] st_writeback = 3'd2;
    localparam logic [ctrl_state_bits-1:0] st_refill    = 3'd3;
    localparam logic [ctrl_state_bits-1:0] st_uncached  = 3'd4;
    localparam logic [ctrl_state_bits-1:0] st_respond   = 3'd5;

endpackage

// File: hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top import dcache_pkg::*; #(
    parameter int line_bits  = 5,
    parameter int index_bits = 6
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 cpu_req,
    input  logic                 cpu_wr,
    input  logic                 cpu_uncached,
    input  logic [word_bits-1:0] cpu_addr,
    input  logic [word_bits-1:0] cpu_wdata,
    input  logic [strb_bits-1:0] cpu_wstrb,
    output logic                 cpu_ack,
    output logic [word_bits-1:0] cpu_rdata,
    output logic [word_bits-1:0] araddr,
    output logic [7:0]           arlen,
    output logic                 arvalid,
    output logic                 rready,
    input  logic                 arready,
    input  logic [word_bits-1:0] rdata,
    input  logic                 rvalid,
    input  logic                 rlast,
    output logic [word_bits-1:0] awaddr,
    output logic [7:0]           awlen,
    output logic                 awvalid,
    output logic [word_bits-1:0] wdata,
    output logic [strb_bits-1:0] wstrb,
    output logic                 wlast,
    output logic                 wvalid,
    output logic                 bready,
    input  logic                 awready,
    input  logic                 wready,
    input  logic                 bvalid
);
    localparam int tag_bits = word_bits - index_bits - line_bits;

    logic [index_bits-1:0] rd_set, wr_set;
    logic [line_bits-3:0]  rd_word, wr_word, beat_idx;
    logic [1:0]            way_we;
    logic [strb_bits-1:0]  wr_strb;
    logic [tag_bits-1:0]   wr_tag, tag0, tag1;
    logic [word_bits-1:0]  wr_data, data0, data1;
    logic                  rd_start, wr_start, wb_next, beat_valid, done;
    logic [word_bits-1:0]  line_addr, wb_word, beat_data;
    logic [line_bits-2:0]  beat_count;

    dcache_ctrl #(.line_bits(line_bits), .index_bits(index_bits)) u_ctrl (.*);

    dcache_way_ram #(.line_bits(line_bits), .index_bits(index_bits)) u_way0 (
        .clk     (clk),
        .rd_set  (rd_set),
        .rd_word (rd_word),
        .we      (way_we[0]),
        .wr_set  (wr_set),
        .wr_word (wr_word),
        .wr_strb (wr_strb),
        .wr_tag  (wr_tag),
        .wr_data (wr_data),
        .tag     (tag0),
        .data    (data0)
    );

    dcache_way_ram #(.line_bits(line_bits), .index_bits(index_bits)) u_way1 (
        .clk     (clk),
        .rd_set  (rd_set),
        .rd_word (rd_word),
        .we      (way_we[1]),
        .wr_set  (wr_set),
        .wr_word (wr_word),
        .wr_strb (wr_strb),
        .wr_tag  (wr_tag),
        .wr_data (wr_data),
        .tag     (tag1),
        .data    (data1)
    );

    axi_burst_master #(.line_bits(line_bits)) u_axi (.*);

endmodule

// File: hw/dcache_way_ram.sv
`timescale 1ns/1ps

module dcache_way_ram import dcache_pkg::*; #(
    parameter int line_bits  = 5,
    parameter int index_bits = 6
) (
    input  logic                                      clk,
    input  logic [index_bits-1:0]                     rd_set,
    input  logic [line_bits-3:0]                      rd_word,
    input  logic                                      we,
    input  logic [index_bits-1:0]                     wr_set,
    input  logic [line_bits-3:0]                      wr_word,
    input  logic [strb_bits-1:0]                      wr_strb,
    input  logic [word_bits-index_bits-line_bits-1:0] wr_tag,
    input  logic [word_bits-1:0]                      wr_data,
    output logic [word_bits-index_bits-line_bits-1:0] tag,
    output logic [word_bits-1:0]                      data
);
    localparam int tag_bits = word_bits - index_bits - line_bits;

    logic [tag_bits-1:0]  tag_mem  [1 << index_bits];
    logic [word_bits-1:0] data_mem [1 << (index_bits + line_bits - 2)];

    always_ff @(posedge clk) begin
        tag  <= tag_mem[rd_set];
        data <= data_mem[{rd_set, rd_word}];
        if (we) begin
            if (wr_word == '0) tag_mem[wr_set] <= wr_tag;  // once per refill
            for (int b = 0; b < strb_bits; b++) begin
                if (wr_strb[b]) data_mem[{wr_set, wr_word}][8*b +: 8] <= wr_data[8*b +: 8];
            end
        end
    end

endmodule
